// File: rtl/stream_pkg.sv
//################################################
// Line formats of the 36-bit and 72-bit streams
// Occupancy 0 always means the whole line is valid
// Bits 71..69 of a 72-bit line carry no information
//################################################
`default_nettype none

package stream_pkg;

   // Line widths
   localparam int W36 = 36;
   localparam int W72 = 72;

   // Payload width of one 36-bit line, also half of a 72-bit payload
   localparam int DW = 32;

   // 36-bit line control fields
   localparam int SOF36    = 32;
   localparam int EOF36    = 33;
   localparam int OCC36_LO = 34;

   // 72-bit line control fields
   localparam int SOF72    = 64;
   localparam int EOF72    = 65;
   localparam int OCC72_LO = 66;

   // Valid byte counts of a last line
   typedef logic [1:0] occ36_t;
   typedef logic [2:0] occ72_t;

   // Packet ends on the first half of a 72-bit line
   localparam occ72_t OCC_END_FIRST [4] = '{3'd4, 3'd1, 3'd2, 3'd3};

   // Packet ends on the second half
   // Full 36-bit last line gives a full 72-bit line
   localparam occ72_t OCC_END_SECOND [4] = '{3'd0, 3'd5, 3'd6, 3'd7};

endpackage

`default_nettype wire

// File: rtl/ctrl_pkg.sv
//################################################
// FSM encodings of the packer and the merge arbiter
// Lane numbers are one bit, so only two lanes exist
//################################################
`default_nettype none

package ctrl_pkg;

   // Packer FSM
   // EMPTY holds nothing, HALF holds the first line of a pair,
   // FULL holds a complete 72-bit line waiting to leave
   typedef enum logic [1:0] {
      EMPTY = 2'd0,
      HALF  = 2'd1,
      FULL  = 2'd2
   } pack_state_t;

   // Merge arbiter FSM
   // IDLE sits between packets, LANE0 and LANE1 lock a lane until eof
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      LANE0 = 2'd1,
      LANE1 = 2'd2
   } merge_state_t;

   // Lane number, 0 is lane a and 1 is lane b
   typedef logic lane_t;

endpackage

`default_nettype wire

// File: rtl/fifo_short.sv
//################################################
// 16-entry synchronous FIFO with src_rdy/dst_rdy
// Read data is taken straight from the array
// No almost-full or level outputs
//################################################
`timescale 1ns/10ps
`default_nettype none

module fifo_short
#(
   parameter int WIDTH = 36
)
(
   input  wire              clk,
   input  wire              reset,
   input  wire              clear_i,
   input  wire [WIDTH-1:0]  data_i,
   input  wire              src_rdy_i,
   output logic             dst_rdy_o,
   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  wire              dst_rdy_i
);

   // Entry count, needs one bit more than the pointers
   localparam logic [4:0] DEPTH = 5'd16;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [3:0]       wr_ptr;
   logic [3:0]       rd_ptr;
   logic [4:0]       count;
   logic             do_write;
   logic             do_read;

   // Ready flags come only from the count, never from the neighbours
   assign dst_rdy_o = (count != DEPTH);
   assign src_rdy_o = (count != 5'd0);

   assign do_write = src_rdy_i & dst_rdy_o;
   assign do_read  = src_rdy_o & dst_rdy_i;

   // Head entry is visible the cycle after it was written
   assign data_o = mem[rd_ptr];

   // Storage array
   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr] <= data_i;
   end

   // Pointers wrap naturally at 16
   always_ff @(posedge clk)
   begin
      if (reset | clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 4'd1;
         if (do_read)
            rd_ptr <= rd_ptr + 4'd1;
         // Simultaneous read and write leaves the count alone
         case ({do_write, do_read})
            2'b10:   count <= count + 5'd1;
            2'b01:   count <= count - 5'd1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/fifo36_to_fifo72.sv
//################################################
// Packs pairs of 36-bit lines into 72-bit lines
// Odd packets leave the second half of the last line stale
// Malformed frames are not detected
//################################################
`timescale 1ns/10ps
`default_nettype none

module fifo36_to_fifo72
#(
   // 0 puts the first line in the upper half, 1 in the lower half
   parameter int LE = 0
)
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        clear_i,
   input  wire [stream_pkg::W36-1:0]  f36_data_i,
   input  wire                        f36_src_rdy_i,
   output logic                       f36_dst_rdy_o,
   output logic [stream_pkg::W72-1:0] f72_data_o,
   output logic                       f72_src_rdy_o,
   input  wire                        f72_dst_rdy_i
);
   import stream_pkg::*;
   import ctrl_pkg::*;

   // Head FIFO side
   logic [W36-1:0] head_data;
   logic           head_src_rdy;
   logic           head_dst_rdy;

   // Fields of the line at the head FIFO output
   logic           in_sof;
   logic           in_eof;
   occ36_t         in_occ;

   // Pack register
   pack_state_t    state;
   logic [DW-1:0]  dat0;
   logic [DW-1:0]  dat1;
   logic           pack_sof;
   logic           pack_eof;
   occ72_t         pack_occ;

   // Tail FIFO side
   logic [W72-1:0] pack_data;
   logic           pack_src_rdy;
   logic           pack_dst_rdy;

   logic           xfer_out;
   logic           load_lo;
   logic           load_hi;

   // Input decoupling, keeps ready paths out of the pack logic
   fifo_short #(.WIDTH(W36)) head_fifo
   (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (f36_data_i),
      .src_rdy_i (f36_src_rdy_i),
      .dst_rdy_o (f36_dst_rdy_o),
      .data_o    (head_data),
      .src_rdy_o (head_src_rdy),
      .dst_rdy_i (head_dst_rdy)
   );

   assign in_sof = head_data[SOF36];
   assign in_eof = head_data[EOF36];
   assign in_occ = head_data[OCC36_LO +: $bits(occ36_t)];

   assign xfer_out = pack_src_rdy & pack_dst_rdy;

   // First half loads when empty, or when the full line leaves this cycle
   assign load_lo = head_src_rdy & ((state == EMPTY) | ((state == FULL) & xfer_out));
   assign load_hi = head_src_rdy & (state == HALF);

   // Blocked only by a full line that cannot leave
   assign head_dst_rdy = (state != FULL) | xfer_out;
   assign pack_src_rdy = (state == FULL);

   // FSM and occupancy, non-eof lines always carry occupancy 0
   always_ff @(posedge clk)
   begin
      if (reset | clear_i)
      begin
         state    <= EMPTY;
         pack_occ <= '0;
      end
      else if (load_lo)
      begin
         // A one-line tail closes the pair early
         state    <= in_eof ? FULL : HALF;
         pack_occ <= in_eof ? OCC_END_FIRST[in_occ] : '0;
      end
      else if (load_hi)
      begin
         state    <= FULL;
         pack_occ <= in_eof ? OCC_END_SECOND[in_occ] : '0;
      end
      else if (xfer_out)
      begin
         state    <= EMPTY;
         pack_occ <= '0;
      end
   end

   // Payload halves, sof from the first line and eof from the last
   always_ff @(posedge clk)
   begin
      if (load_lo)
      begin
         dat0     <= head_data[DW-1:0];
         pack_sof <= in_sof;
         pack_eof <= in_eof;
      end
      else if (load_hi)
      begin
         dat1     <= head_data[DW-1:0];
         pack_eof <= in_eof;
      end
   end

   // Build the 72-bit line, padding bits stay zero
   // LE 0 puts the first line on top
   assign pack_data = {3'b000, pack_occ, pack_eof, pack_sof,
                       ((LE == 0) ? {dat0, dat1} : {dat1, dat0})};

   // Output decoupling toward the merger
   fifo_short #(.WIDTH(W72)) tail_fifo
   (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (pack_data),
      .src_rdy_i (pack_src_rdy),
      .dst_rdy_o (pack_dst_rdy),
      .data_o    (f72_data_o),
      .src_rdy_o (f72_src_rdy_o),
      .dst_rdy_i (f72_dst_rdy_i)
   );

endmodule

`default_nettype wire

// File: rtl/fifo72_merge.sv
//################################################
// Round-robin merge of two 72-bit packet streams
// Packets stay whole, a granted lane holds until eof
// Data and ready pass through with no added cycle
//################################################
`timescale 1ns/10ps
`default_nettype none

module fifo72_merge
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        clear_i,
   input  wire [stream_pkg::W72-1:0]  a_data_i,
   input  wire                        a_src_rdy_i,
   output logic                       a_dst_rdy_o,
   input  wire [stream_pkg::W72-1:0]  b_data_i,
   input  wire                        b_src_rdy_i,
   output logic                       b_dst_rdy_o,
   output logic [stream_pkg::W72-1:0] out_data_o,
   output logic                       out_src_rdy_o,
   output ctrl_pkg::lane_t            out_lane_o,
   input  wire                        out_dst_rdy_i
);
   import stream_pkg::*;
   import ctrl_pkg::*;

   merge_state_t state;

   // Lane granted for the most recent packet
   lane_t        last_grant;

   // Lane currently steering the output mux
   lane_t        sel;

   logic         xfer;

   // Lane choice
   // A locked state wins, otherwise a lone ready lane,
   // otherwise the lane not served last
   always_comb
   begin
      case (state)
         LANE0:   sel = 1'b0;
         LANE1:   sel = 1'b1;
         default:
         begin
            if (a_src_rdy_i & b_src_rdy_i)
               sel = ~last_grant;
            else
               sel = b_src_rdy_i;
         end
      endcase
   end

   // Output mux for the selected lane
   assign out_data_o    = sel ? b_data_i : a_data_i;
   assign out_src_rdy_o = sel ? b_src_rdy_i : a_src_rdy_i;
   assign out_lane_o    = sel;

   // The other lane sees no ready until the packet is through
   assign a_dst_rdy_o = ~sel & out_dst_rdy_i;
   assign b_dst_rdy_o = sel & out_dst_rdy_i;

   assign xfer = out_src_rdy_o & out_dst_rdy_i;

   // Lock the lane as soon as it shows a line, even a stalled one,
   // so the output cannot switch under back-pressure
   always_ff @(posedge clk)
   begin
      if (reset | clear_i)
      begin
         state      <= IDLE;
         // Pretend lane b went last, so lane a gets the first tie
         last_grant <= 1'b1;
      end
      else
      begin
         if (xfer & out_data_o[EOF72])
            state <= IDLE;
         else if (out_src_rdy_o)
            state <= sel ? LANE1 : LANE0;

         // Grant is recorded once per packet, when leaving IDLE
         if ((state == IDLE) & out_src_rdy_o)
            last_grant <= sel;
      end
   end

endmodule

`default_nettype wire

// File: rtl/dual_fifo36_to_fifo72.sv
//################################################
// Two 36-to-72 packers feeding a packet merger
// LE applies to both lanes alike
//################################################
`timescale 1ns/10ps
`default_nettype none

module dual_fifo36_to_fifo72
#(
   parameter int LE = 0
)
(
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        clear_i,
   input  wire [stream_pkg::W36-1:0]  in_a_data_i,
   input  wire                        in_a_src_rdy_i,
   output logic                       in_a_dst_rdy_o,
   input  wire [stream_pkg::W36-1:0]  in_b_data_i,
   input  wire                        in_b_src_rdy_i,
   output logic                       in_b_dst_rdy_o,
   output logic [stream_pkg::W72-1:0] out_data_o,
   output logic                       out_src_rdy_o,
   output ctrl_pkg::lane_t            out_lane_o,
   input  wire                        out_dst_rdy_i
);
   import stream_pkg::*;

   // Packed lane a toward the merger
   logic [W72-1:0] a72_data;
   logic           a72_src_rdy;
   logic           a72_dst_rdy;

   // Packed lane b toward the merger
   logic [W72-1:0] b72_data;
   logic           b72_src_rdy;
   logic           b72_dst_rdy;

   fifo36_to_fifo72 #(.LE(LE)) u_pack_a
   (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f36_data_i    (in_a_data_i),
      .f36_src_rdy_i (in_a_src_rdy_i),
      .f36_dst_rdy_o (in_a_dst_rdy_o),
      .f72_data_o    (a72_data),
      .f72_src_rdy_o (a72_src_rdy),
      .f72_dst_rdy_i (a72_dst_rdy)
   );

   fifo36_to_fifo72 #(.LE(LE)) u_pack_b
   (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f36_data_i    (in_b_data_i),
      .f36_src_rdy_i (in_b_src_rdy_i),
      .f36_dst_rdy_o (in_b_dst_rdy_o),
      .f72_data_o    (b72_data),
      .f72_src_rdy_o (b72_src_rdy),
      .f72_dst_rdy_i (b72_dst_rdy)
   );

   // Lane a is lane 0, lane b is lane 1
   fifo72_merge u_merge
   (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .a_data_i      (a72_data),
      .a_src_rdy_i   (a72_src_rdy),
      .a_dst_rdy_o   (a72_dst_rdy),
      .b_data_i      (b72_data),
      .b_src_rdy_i   (b72_src_rdy),
      .b_dst_rdy_o   (b72_dst_rdy),
      .out_data_o    (out_data_o),
      .out_src_rdy_o (out_src_rdy_o),
      .out_lane_o    (out_lane_o),
      .out_dst_rdy_i (out_dst_rdy_i)
   );

endmodule

`default_nettype wire

// File: bench/dual_fifo36_to_fifo72_properties.sv
//################################################
// Output protocol assertions, bound to the top level
// Lane check covers accepted sof through eof only
//################################################
`timescale 1ns/10ps
`default_nettype none

module dual_fifo36_to_fifo72_properties
(
   input wire                       clk,
   input wire                       reset,
   input wire                       clear_i,
   input wire [stream_pkg::W72-1:0] data_i,
   input wire                       src_rdy_i,
   input wire                       dst_rdy_i,
   input wire                       lane_i
);
   import stream_pkg::*;
   import ctrl_pkg::*;

   // Inside a packet since its sof line was accepted
   logic  in_pkt;
   lane_t pkt_lane;

   always_ff @(posedge clk)
   begin
      if (reset | clear_i)
         in_pkt <= 1'b0;
      else if (src_rdy_i & dst_rdy_i)
      begin
         if (data_i[SOF72])
            pkt_lane <= lane_i;
         if (data_i[EOF72])
            in_pkt <= 1'b0;
         else if (data_i[SOF72])
            in_pkt <= 1'b1;
      end
   end

   // Nothing offered right after reset
   assert property (@(posedge clk) reset |=> !src_rdy_i)
      else $error("output valid right after reset");

   // Stalled line holds still
   assert property (@(posedge clk)
      (src_rdy_i && !dst_rdy_i && !reset && !clear_i) |=>
         ($stable(data_i) && $stable(lane_i)))
      else $error("output changed while stalled");

   assert property (@(posedge clk) disable iff (reset)
      src_rdy_i |-> (data_i[W72-1:69] == 3'b000))
      else $error("padding bits not zero");

   // One lane from sof to eof
   assert property (@(posedge clk) disable iff (reset)
      (in_pkt && src_rdy_i && !clear_i) |-> (lane_i == pkt_lane))
      else $error("lane switched inside a packet");

endmodule

bind dual_fifo36_to_fifo72 dual_fifo36_to_fifo72_properties u_properties
(
   .clk       (clk),
   .reset     (reset),
   .clear_i   (clear_i),
   .data_i    (out_data_o),
   .src_rdy_i (out_src_rdy_o),
   .dst_rdy_i (out_dst_rdy_i),
   .lane_i    (out_lane_o)
);

`default_nettype wire

// File: bench/dual_fifo36_to_fifo72_tb.sv
//################################################
// Testbench of the two-lane packer and merger
// The model packs lines by the 36-to-72 rules
// LE here must match the DUT's LE
//################################################
`timescale 1ns/10ps
`default_nettype none

module dual_fifo36_to_fifo72_tb;

   parameter int LE = 0;

   logic        clk;
   logic        reset;
   logic        clear_i;
   logic [35:0] in_data [2];
   logic [1:0]  in_src_rdy;
   wire  [1:0]  in_dst_rdy;
   wire  [71:0] out_data_o;
   wire         out_src_rdy_o;
   wire         out_lane_o;
   logic        out_dst_rdy_i;

   // Stimulus lines and expected 72-bit lines per lane, read and write indices
   logic [35:0] stim_mem [2][2048];
   logic [71:0] exp_mem  [2][2048];
   logic [71:0] mask_mem [2][2048];
   int          stim_wr [2];
   int          stim_rd [2];
   int          exp_wr [2];
   int          exp_rd [2];

   integer      seed;
   int          errors;
   int          checks;
   int          rx_count;
   int          test_errors;
   int          bp_mode;
   bit          gap_en;
   bit          in_pkt;
   logic        pkt_lane;
   int          lane_idx;
   logic [71:0] mon_mask;
   int          rx_snap;
   int          len;

   dual_fifo36_to_fifo72 #(.LE(LE)) u_dual_fifo36_to_fifo72
   (
      .clk            (clk),
      .reset          (reset),
      .clear_i        (clear_i),
      .in_a_data_i    (in_data[0]),
      .in_a_src_rdy_i (in_src_rdy[0]),
      .in_a_dst_rdy_o (in_dst_rdy[0]),
      .in_b_data_i    (in_data[1]),
      .in_b_src_rdy_i (in_src_rdy[1]),
      .in_b_dst_rdy_o (in_dst_rdy[1]),
      .out_data_o     (out_data_o),
      .out_src_rdy_o  (out_src_rdy_o),
      .out_lane_o     (out_lane_o),
      .out_dst_rdy_i  (out_dst_rdy_i)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   task check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
      begin
         checks = checks + 1;
         if (got !== exp)
         begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors = errors + 1;
         end
      end
   endtask

   // One 36-bit line, occupancy only on the last line of a packet
   function logic [35:0] make_line(input bit sof, input bit eof, input int occ_sel);
      logic [1:0]  occ;
      logic [31:0] data;
      begin
         occ  = 2'd0;
         data = $random(seed);
         if (eof)
            occ = (occ_sel < 0) ? ($random(seed) & 3) : occ_sel;
         make_line = {occ, eof, sof, data};
      end
   endfunction

   // Queue stimulus and, for a closed packet, the expected packed lines
   task gen_packet(input int lane, input int plen, input int occ_sel, input bit close);
      logic [35:0] line0;
      logic [35:0] line1;
      logic [2:0]  occ72;
      logic [63:0] data64;
      logic [71:0] mask;
      int          i;
      begin
         for (i = 0; i < plen; i = i + 2)
         begin
            line0 = make_line(i == 0, close && (i == plen - 1), occ_sel);
            stim_mem[lane][stim_wr[lane]] = line0;
            stim_wr[lane] = stim_wr[lane] + 1;
            mask = {72{1'b1}};
            if (i + 1 < plen)
            begin
               line1 = make_line(1'b0, close && (i + 1 == plen - 1), occ_sel);
               stim_mem[lane][stim_wr[lane]] = line1;
               stim_wr[lane] = stim_wr[lane] + 1;
               // Ends on second half: 0 stays 0, n becomes n+4
               occ72 = (line1[35:34] == 2'd0) ? 3'd0 : {1'b1, line1[35:34]};
               data64 = (LE == 0) ? {line0[31:0], line1[31:0]} : {line1[31:0], line0[31:0]};
               line0[33] = line1[33];
            end
            else
            begin
               // Ends on first half: 0 becomes 4, other half is unused
               occ72 = (line0[35:34] == 2'd0) ? 3'd4 : {1'b0, line0[35:34]};
               data64 = (LE == 0) ? {line0[31:0], 32'd0} : {32'd0, line0[31:0]};
               mask[31:0] = (LE == 0) ? 32'd0 : 32'hffffffff;
               mask[63:32] = (LE == 0) ? 32'hffffffff : 32'd0;
            end
            if (close)
            begin
               exp_mem[lane][exp_wr[lane]] = {3'b000, occ72, line0[33], line0[32], data64};
               mask_mem[lane][exp_wr[lane]] = mask;
               exp_wr[lane] = exp_wr[lane] + 1;
            end
         end
      end
   endtask

   function bit lanes_idle(input bit with_exp);
      begin
         lanes_idle = (stim_rd[0] == stim_wr[0]) && (stim_rd[1] == stim_wr[1]);
         if (with_exp)
            lanes_idle = lanes_idle && (exp_rd[0] == exp_wr[0]) && (exp_rd[1] == exp_wr[1]);
      end
   endfunction

   // Loop until everything queued has gone through, or give up
   task wait_idle(input bit with_exp, input string what);
      int cycles;
      begin
         cycles = 0;
         while (!lanes_idle(with_exp) && cycles < 5000)
         begin
            @(posedge clk);
            cycles = cycles + 1;
         end
         if (!lanes_idle(with_exp))
         begin
            $display("Timeout while waiting for %s", what);
            errors = errors + 1;
         end
      end
   endtask

   task finish_test(input string name);
      begin
         $display("Test %s finished with %0d errors", name, errors - test_errors);
         test_errors = errors;
      end
   endtask

   // Input drivers, a stalled line is held until accepted
   always @(posedge clk)
   begin
      for (int l = 0; l < 2; l++)
      begin
         if (reset | clear_i)
            in_src_rdy[l] <= 1'b0;
         else if (!(in_src_rdy[l] & !in_dst_rdy[l]))
         begin
            if (in_src_rdy[l])
               stim_rd[l] = stim_rd[l] + 1;
            if ((stim_rd[l] != stim_wr[l]) && (!gap_en || (($random(seed) & 3) != 0)))
            begin
               in_src_rdy[l] <= 1'b1;
               in_data[l]    <= stim_mem[l][stim_rd[l]];
            end
            else
               in_src_rdy[l] <= 1'b0;
         end
      end
   end

   // Output back-pressure, 0 ready, 1 random, 2 stalled
   always @(posedge clk)
   begin
      if (bp_mode == 2)
         out_dst_rdy_i <= 1'b0;
      else if (bp_mode == 1)
         out_dst_rdy_i <= (($random(seed) & 3) != 0);
      else
         out_dst_rdy_i <= 1'b1;
   end

   // Output monitor
   always @(posedge clk)
   begin
      if (!reset && !clear_i && out_src_rdy_o && out_dst_rdy_i)
      begin
         lane_idx = out_lane_o;
         if (exp_rd[lane_idx] == exp_wr[lane_idx])
         begin
            $display("Unexpected output line on lane %0d", lane_idx);
            errors = errors + 1;
         end
         else
         begin
            mon_mask = mask_mem[lane_idx][exp_rd[lane_idx]];
            check_value("out_data_o", out_data_o & mon_mask,
                        exp_mem[lane_idx][exp_rd[lane_idx]] & mon_mask);
            exp_rd[lane_idx] = exp_rd[lane_idx] + 1;
         end
         // Packet must not be split across lanes
         if (in_pkt)
            check_value("out_lane_o", out_lane_o, pkt_lane);
         if (out_data_o[64])
         begin
            in_pkt   = 1'b1;
            pkt_lane = out_lane_o;
         end
         if (out_data_o[65])
            in_pkt = 1'b0;
         rx_count = rx_count + 1;
      end
   end

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      clear_i = 1'b0;
      in_data[0] = '0;
      in_data[1] = '0;
      in_src_rdy = 2'b00;
      out_dst_rdy_i = 1'b0;
      seed = 32'haf9d;
      errors = 0;
      checks = 0;
      rx_count = 0;
      test_errors = 0;
      bp_mode = 0;
      gap_en = 1'b0;
      in_pkt = 1'b0;
      for (int l = 0; l < 2; l++)
      begin
         stim_wr[l] = 0;
         stim_rd[l] = 0;
         exp_wr[l] = 0;
         exp_rd[l] = 0;
      end
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // Lane a alone, even lengths
      for (int p = 0; p < 4; p++)
      begin
         len = 2 * (1 + ($unsigned($random(seed)) % 4));
         gen_packet(0, len, -1, 1'b1);
      end
      wait_idle(1'b1, "even packets");
      finish_test("even_single_lane");

      // Lane b, odd and even lengths for every last occupancy
      for (int occ = 0; occ < 4; occ++)
      begin
         gen_packet(1, 1 + 2 * ($unsigned($random(seed)) % 5), occ, 1'b1);
         gen_packet(1, 2 * (1 + ($unsigned($random(seed)) % 4)), occ, 1'b1);
      end
      wait_idle(1'b1, "odd packets");
      finish_test("odd_and_occupancy");

      // Both lanes with input gaps
      gap_en = 1'b1;
      for (int p = 0; p < 8; p++)
      begin
         gen_packet(0, 1 + ($unsigned($random(seed)) % 9), -1, 1'b1);
         gen_packet(1, 1 + ($unsigned($random(seed)) % 9), -1, 1'b1);
      end
      wait_idle(1'b1, "interleaved packets");
      finish_test("two_lanes_gaps");

      // Output back-pressure on top of input gaps
      bp_mode = 1;
      for (int p = 0; p < 10; p++)
      begin
         gen_packet(0, 1 + ($unsigned($random(seed)) % 9), -1, 1'b1);
         gen_packet(1, 1 + ($unsigned($random(seed)) % 9), -1, 1'b1);
      end
      wait_idle(1'b1, "back-pressured packets");
      finish_test("back_pressure");

      // Stall the output, load partial packets, then clear
      bp_mode = 2;
      gap_en = 1'b0;
      repeat (2) @(posedge clk);
      gen_packet(0, 5, -1, 1'b0);
      gen_packet(1, 5, -1, 1'b0);
      wait_idle(1'b0, "partial packets to enter");
      repeat (5) @(posedge clk);
      clear_i <= 1'b1;
      @(posedge clk);
      clear_i <= 1'b0;
      for (int l = 0; l < 2; l++)
      begin
         stim_rd[l] = stim_wr[l];
         exp_rd[l] = exp_wr[l];
      end
      in_pkt = 1'b0;
      bp_mode = 0;
      rx_snap = rx_count;
      // Nothing may come out of an emptied DUT
      repeat (20) @(posedge clk);
      check_value("rx_count", rx_count, rx_snap);
      for (int p = 0; p < 3; p++)
      begin
         gen_packet(0, 2 * (1 + ($unsigned($random(seed)) % 4)), -1, 1'b1);
         gen_packet(1, 2 * (1 + ($unsigned($random(seed)) % 4)), -1, 1'b1);
      end
      wait_idle(1'b1, "packets after clear");
      finish_test("clear");

      $display("Checks %0d, lines received %0d, errors %0d", checks, rx_count, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: dual_fifo36_to_fifo72.f
rtl/stream_pkg.sv
rtl/ctrl_pkg.sv
rtl/fifo_short.sv
rtl/fifo36_to_fifo72.sv
rtl/fifo72_merge.sv
rtl/dual_fifo36_to_fifo72.sv
bench/dual_fifo36_to_fifo72_properties.sv
bench/dual_fifo36_to_fifo72_tb.sv
